/* logic/mem_pkg.sv */
package mem_pkg;

  // **************************************************
  // memory port commands
  // **************************************************

  // one command per cycle, no handshake back.
  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_READ  = 2'd2
  } mem_cmd_t;

  // **************************************************
  // burst scheduler states
  // **************************************************

  typedef enum logic [1:0] {
    ST_WAIT_INIT = 2'd0,
    ST_IDLE      = 2'd1,
    ST_WRITE     = 2'd2,
    ST_READ      = 2'd3
  } sched_state_t;

endpackage

/* logic/stream_pkg.sv */
package stream_pkg;

  // **************************************************
  // user word to memory word mapping
  // **************************************************

  // which user word of a memory word is current.
  // the low half carries the earlier word.
  typedef enum logic {
    HALF_LO = 1'b0,
    HALF_HI = 1'b1
  } half_t;

endpackage

/* logic/word_packer.sv */
`timescale 1ns/1ps

module word_packer
  import stream_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    clk0_tb,
  input  logic                    locked,
  input  logic                    in_valid,
  input  logic [DATA_WIDTH-1:0]   in_data,
  input  logic                    push_ready,
  input  logic                    enable,
  output logic                    in_ready,
  output logic                    push_valid,
  output logic [2*DATA_WIDTH-1:0] push_data
);

  half_t                  half;
  logic [DATA_WIDTH-1:0]  lo_word;
  logic                   in_take;

  // stall while the packed word waits in the output register.
  assign in_ready = enable && (!push_valid || push_ready);
  assign in_take  = in_valid && in_ready;

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      half       <= HALF_LO;
      push_valid <= 1'b0;
    end else begin
      if (push_valid && push_ready) begin
        push_valid <= 1'b0;
      end
      if (in_take) begin
        if (half == HALF_LO) begin
          half <= HALF_HI;
        end else begin
          half       <= HALF_LO;
          push_valid <= 1'b1;
        end
      end
    end
  end

  // payload path.
  always_ff @(posedge clk0_tb) begin
    if (in_take) begin
      if (half == HALF_LO) begin
        lo_word <= in_data;
      end else begin
        push_data <= {in_data, lo_word};
      end
    end
  end

endmodule

/* logic/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo #(
  parameter int W     = 64,
  parameter int DEPTH = 16
) (
  input  logic                     clk0_tb,
  input  logic                     locked,
  input  logic                     push,
  input  logic [W-1:0]             push_data,
  input  logic                     pop,
  output logic                     full,
  output logic                     pop_valid,
  output logic [W-1:0]             pop_data,
  output logic [$clog2(DEPTH):0]   count
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH) + 1;

  logic [W-1:0]  mem_array [0:DEPTH-1];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          push_ok;
  logic          pop_ok;

  assign full      = (count == CW'(DEPTH));
  assign pop_valid = (count != '0);
  // head word shows without a pop.
  assign pop_data  = mem_array[rd_ptr];

  assign push_ok = push && !full;
  assign pop_ok  = pop && pop_valid;

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage.
  always_ff @(posedge clk0_tb) begin
    if (push_ok) begin
      mem_array[wr_ptr] <= push_data;
    end
  end

endmodule

/* logic/burst_scheduler.sv */
`timescale 1ns/1ps

module burst_scheduler
  import mem_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int BURST_LEN  = 4,
  parameter int ADDR_WIDTH = 6,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        clk0_tb,
  input  logic                        locked,
  input  logic                        init_done,
  input  logic [$clog2(FIFO_DEPTH):0] wr_count,
  input  logic                        wr_valid,
  input  logic [2*DATA_WIDTH-1:0]     wr_data,
  input  logic [$clog2(FIFO_DEPTH):0] rd_count,
  input  logic                        rd_valid,
  output logic                        wr_pop,
  output mem_cmd_t                    cmd,
  output logic [ADDR_WIDTH-1:0]       addr,
  output logic [2*DATA_WIDTH-1:0]     wdata
);

  localparam int CW = $clog2(FIFO_DEPTH) + 1;
  localparam int BW = $clog2(BURST_LEN + 1);

  sched_state_t          state;
  logic [BW-1:0]         beat;
  logic [ADDR_WIDTH-1:0] base;
  logic [CW-1:0]         in_flight;
  logic                  rd_go;
  logic [CW:0]           rd_level;
  logic                  rd_room;
  logic                  wr_issue;
  logic                  rd_issue;
  logic                  last_beat;

  // **************************************************
  // issue decisions
  // **************************************************

  // words already buffered plus words still on their way back.
  assign rd_level  = {1'b0, rd_count} + {1'b0, in_flight};
  assign rd_room   = rd_level <= (CW + 1)'(FIFO_DEPTH - BURST_LEN);
  assign wr_issue  = (state == ST_WRITE) && wr_valid;
  // room is checked once, then the whole burst goes out.
  assign rd_issue  = (state == ST_READ) && (rd_go || rd_room);
  assign last_beat = (beat == BW'(BURST_LEN - 1));

  assign wr_pop = wr_issue;
  assign addr   = base + ADDR_WIDTH'(beat);
  assign wdata  = wr_data;

  always_comb begin
    if (wr_issue) begin
      cmd = CMD_WRITE;
    end else if (rd_issue) begin
      cmd = CMD_READ;
    end else begin
      cmd = CMD_NOP;
    end
  end

  // **************************************************
  // state machine
  // **************************************************

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      state <= ST_WAIT_INIT;
      beat  <= '0;
      base  <= '0;
      rd_go <= 1'b0;
    end else begin
      case (state)
        ST_WAIT_INIT: begin
          if (init_done) begin
            state <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (wr_count >= CW'(BURST_LEN)) begin
            state <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          if (wr_issue) begin
            if (last_beat) begin
              beat  <= '0;
              state <= ST_READ;
            end else begin
              beat <= beat + 1'b1;
            end
          end
        end
        ST_READ: begin
          if (rd_issue) begin
            if (last_beat) begin
              beat  <= '0;
              rd_go <= 1'b0;
              // wraps at the top of the memory.
              base  <= base + ADDR_WIDTH'(BURST_LEN);
              state <= ST_IDLE;
            end else begin
              beat  <= beat + 1'b1;
              rd_go <= 1'b1;
            end
          end
        end
        default: state <= ST_WAIT_INIT;
      endcase
    end
  end

  // reads issued but not yet returned.
  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      in_flight <= '0;
    end else begin
      case ({rd_issue, rd_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

endmodule

/* logic/burst_memory.sv */
`timescale 1ns/1ps

module burst_memory
  import mem_pkg::*;
#(
  parameter int DATA_WIDTH  = 32,
  parameter int ADDR_WIDTH  = 6,
  parameter int READ_LAT    = 2,
  parameter int INIT_CYCLES = 32
) (
  input  logic                    clk0_tb,
  input  logic                    locked,
  input  mem_cmd_t                cmd,
  input  logic [ADDR_WIDTH-1:0]   addr,
  input  logic [2*DATA_WIDTH-1:0] wdata,
  output logic                    init_done,
  output logic                    rd_valid,
  output logic [2*DATA_WIDTH-1:0] rd_data
);

  localparam int MW        = 2 * DATA_WIDTH;
  localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;
  localparam int IW        = $clog2(INIT_CYCLES + 1);

  logic [MW-1:0]       mem_array [0:MEM_DEPTH-1];
  logic [IW-1:0]       init_cnt;
  logic [READ_LAT-1:0] vld_pipe;
  logic [MW-1:0]       dat_pipe [0:READ_LAT-1];

  // **************************************************
  // power-up wait
  // **************************************************

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      init_cnt  <= '0;
      init_done <= 1'b0;
    end else if (!init_done) begin
      if (init_cnt == IW'(INIT_CYCLES - 1)) begin
        init_done <= 1'b1;
      end else begin
        init_cnt <= init_cnt + 1'b1;
      end
    end
  end

  // **************************************************
  // array and read pipeline
  // **************************************************

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= (cmd == CMD_READ);
      for (int i = 1; i < READ_LAT; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  // stage 0 samples the array with the read command.
  always_ff @(posedge clk0_tb) begin
    if (cmd == CMD_WRITE) begin
      mem_array[addr] <= wdata;
    end
    dat_pipe[0] <= mem_array[addr];
    for (int i = 1; i < READ_LAT; i++) begin
      dat_pipe[i] <= dat_pipe[i-1];
    end
  end

  assign rd_valid = vld_pipe[READ_LAT-1];
  assign rd_data  = dat_pipe[READ_LAT-1];

endmodule

/* logic/word_unpacker.sv */
`timescale 1ns/1ps

module word_unpacker
  import stream_pkg::*;
#(
  parameter int DATA_WIDTH = 32
) (
  input  logic                    clk0_tb,
  input  logic                    locked,
  input  logic                    pop_valid,
  input  logic [2*DATA_WIDTH-1:0] pop_data,
  input  logic                    out_ready,
  output logic                    pop,
  output logic                    out_valid,
  output logic [DATA_WIDTH-1:0]   out_data
);

  half_t half;
  logic  out_take;

  // the fifo head stays put until popped, so data holds.
  assign out_valid = pop_valid;
  assign out_take  = out_valid && out_ready;

  always_comb begin
    if (half == HALF_LO) begin
      out_data = pop_data[DATA_WIDTH-1:0];
    end else begin
      out_data = pop_data[2*DATA_WIDTH-1:DATA_WIDTH];
    end
  end

  // memory word is done once its high half leaves.
  assign pop = out_take && (half == HALF_HI);

  always_ff @(posedge clk0_tb or negedge locked) begin
    if (!locked) begin
      half <= HALF_LO;
    end else if (out_take) begin
      if (half == HALF_LO) begin
        half <= HALF_HI;
      end else begin
        half <= HALF_LO;
      end
    end
  end

endmodule

/* logic/mem_loop_top.sv */
`timescale 1ns/1ps

module mem_loop_top
  import mem_pkg::*;
#(
  parameter int DATA_WIDTH  = 32,
  parameter int BURST_LEN   = 4,
  parameter int ADDR_WIDTH  = 6,
  parameter int FIFO_DEPTH  = 16,
  parameter int READ_LAT    = 2,
  parameter int INIT_CYCLES = 32
) (
  input  logic                  clk0_tb,
  input  logic                  locked,
  input  logic                  in_valid,
  input  logic [DATA_WIDTH-1:0] in_data,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ready,
  output logic                  init_done
);

  localparam int MW = 2 * DATA_WIDTH;
  localparam int CW = $clog2(FIFO_DEPTH) + 1;

  logic                  push_valid;
  logic [MW-1:0]         push_data;
  logic                  push_ready;
  logic                  wr_full;
  logic                  wr_valid;
  logic [MW-1:0]         wr_data;
  logic                  wr_pop;
  logic [CW-1:0]         wr_count;
  mem_cmd_t              cmd;
  logic [ADDR_WIDTH-1:0] addr;
  logic [MW-1:0]         wdata;
  logic                  rd_valid;
  logic [MW-1:0]         rd_data;
  logic                  rd_pop_valid;
  logic [MW-1:0]         rd_pop_data;
  logic                  rd_pop;
  logic [CW-1:0]         rd_count;

  assign push_ready = !wr_full;

  // **************************************************
  // input side
  // **************************************************

  word_packer #(.DATA_WIDTH(DATA_WIDTH)) u_packer (
    .clk0_tb    (clk0_tb),
    .locked     (locked),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .push_ready (push_ready),
    .enable     (init_done),
    .in_ready   (in_ready),
    .push_valid (push_valid),
    .push_data  (push_data)
  );

  // **************************************************
  // write buffer, scheduler, memory, read buffer
  // **************************************************

  word_fifo #(.W(MW), .DEPTH(FIFO_DEPTH)) wr_buf (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .push      (push_valid),
    .push_data (push_data),
    .pop       (wr_pop),
    .full      (wr_full),
    .pop_valid (wr_valid),
    .pop_data  (wr_data),
    .count     (wr_count)
  );

  burst_scheduler #(
    .DATA_WIDTH (DATA_WIDTH),
    .BURST_LEN  (BURST_LEN),
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sched (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .init_done (init_done),
    .wr_count  (wr_count),
    .wr_valid  (wr_valid),
    .wr_data   (wr_data),
    .rd_count  (rd_count),
    .rd_valid  (rd_valid),
    .wr_pop    (wr_pop),
    .cmd       (cmd),
    .addr      (addr),
    .wdata     (wdata)
  );

  burst_memory #(
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .READ_LAT    (READ_LAT),
    .INIT_CYCLES (INIT_CYCLES)
  ) u_mem (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .cmd       (cmd),
    .addr      (addr),
    .wdata     (wdata),
    .init_done (init_done),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  // scheduler keeps room for every read in flight.
  word_fifo #(.W(MW), .DEPTH(FIFO_DEPTH)) rd_buf (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .push      (rd_valid),
    .push_data (rd_data),
    .pop       (rd_pop),
    .full      (),
    .pop_valid (rd_pop_valid),
    .pop_data  (rd_pop_data),
    .count     (rd_count)
  );

  // **************************************************
  // output side
  // **************************************************

  word_unpacker #(.DATA_WIDTH(DATA_WIDTH)) u_unpacker (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .pop_valid (rd_pop_valid),
    .pop_data  (rd_pop_data),
    .out_ready (out_ready),
    .pop       (rd_pop),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk0_tb,
  output logic locked
);

  // 20 ns period.
  initial begin
    clk0_tb = 1'b0;
    forever #10 clk0_tb = ~clk0_tb;
  end

  // released just after an edge.
  initial begin
    locked = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk0_tb);
    #2;
    locked = 1'b1;
  end

endmodule

/* tests/tb_assert.sv */
`timescale 1ns/1ps

module tb_assert #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 16
) (
  input logic                        clk0_tb,
  input logic                        locked,
  input logic                        in_ready,
  input logic                        init_done,
  input logic                        out_valid,
  input logic                        out_ready,
  input logic [DATA_WIDTH-1:0]       out_data,
  input logic                        rd_valid,
  input logic [$clog2(FIFO_DEPTH):0] rd_count
);

  localparam int CW = $clog2(FIFO_DEPTH) + 1;

  // **************************************************
  // user handshakes
  // **************************************************

  // a stalled word holds until taken.
  out_hold: assert property (@(posedge clk0_tb) disable iff (!locked)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("out_data or out_valid changed while the output word was stalled");

  in_gate: assert property (@(posedge clk0_tb) disable iff (!locked)
    !init_done |-> !in_ready)
    else $error("in_ready was high before init_done");

  // **************************************************
  // read buffer level
  // **************************************************

  // a returning read must find a free slot.
  rd_room: assert property (@(posedge clk0_tb) disable iff (!locked)
    rd_valid |-> rd_count != CW'(FIFO_DEPTH))
    else $error("read data arrived while the read buffer was full");

endmodule

bind mem_loop_top tb_assert #(
  .DATA_WIDTH (DATA_WIDTH),
  .FIFO_DEPTH (FIFO_DEPTH)
) u_assert (
  .clk0_tb   (clk0_tb),
  .locked    (locked),
  .in_ready  (in_ready),
  .init_done (init_done),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .rd_valid  (rd_valid),
  .rd_count  (rd_count)
);

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  localparam int DATA_WIDTH  = 32;
  localparam int BURST_LEN   = 4;
  localparam int ADDR_WIDTH  = 6;
  localparam int FIFO_DEPTH  = 16;
  localparam int READ_LAT    = 2;
  localparam int INIT_CYCLES = 32;

  localparam logic [31:0] SEED = 32'h3d5c_355a;

  // words over all tests, 40 cycles each.
  localparam int TOTAL_WORDS = 64 + 128 + 2 * BURST_LEN + 600;
  localparam int MAX_CYCLES  = INIT_CYCLES + 40 * TOTAL_WORDS;

  logic                  clk0_tb;
  logic                  locked;
  logic                  in_valid;
  logic [DATA_WIDTH-1:0] in_data;
  logic                  in_ready;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_ready;
  logic                  init_done;

  logic [31:0]           rng_in;
  logic [31:0]           rng_out;
  int                    ready_pct;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    out_count;
  logic [DATA_WIDTH-1:0] exp_q [$];

  tb_clock u_clock (
    .clk0_tb (clk0_tb),
    .locked  (locked)
  );

  mem_loop_top #(
    .DATA_WIDTH  (DATA_WIDTH),
    .BURST_LEN   (BURST_LEN),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .READ_LAT    (READ_LAT),
    .INIT_CYCLES (INIT_CYCLES)
  ) dut (
    .clk0_tb   (clk0_tb),
    .locked    (locked),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .init_done (init_done)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // **************************************************
  // reference model
  // **************************************************

  // sampled mid-cycle, where every handshake signal is settled.
  always @(negedge clk0_tb) begin : monitor
    logic [DATA_WIDTH-1:0] expected;
    if (locked) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(in_data);
      end
      if (out_valid && out_ready) begin
        out_count = out_count + 1;
        if (exp_q.size() == 0) begin
          $display("output word 0x%h arrived with no input word outstanding", out_data);
          errors = errors + 1;
        end else begin
          expected = exp_q.pop_front();
          if (out_data !== expected) begin
            $display("mismatch out_data: expected 0x%h, actual 0x%h", expected, out_data);
            errors = errors + 1;
          end
        end
      end
    end
  end

  // output side, own random stream.
  always @(posedge clk0_tb) begin
    #2;
    rng_out   = xorshift32(rng_out);
    out_ready = (rng_out % 100) < ready_pct;
  end

  // **************************************************
  // stimulus helpers
  // **************************************************

  task automatic send_words(input int n, input int gap_pct);
    logic took;
    @(posedge clk0_tb);
    #2;
    for (int k = 0; k < n; k++) begin
      rng_in = xorshift32(rng_in);
      while ((rng_in % 100) < gap_pct) begin
        @(posedge clk0_tb);
        #2;
        rng_in = xorshift32(rng_in);
      end
      rng_in   = xorshift32(rng_in);
      in_valid = 1'b1;
      in_data  = rng_in;
      took     = 1'b0;
      while (!took) begin
        @(negedge clk0_tb);
        took = in_ready;
        @(posedge clk0_tb);
        #2;
      end
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_output(input int target);
    while (out_count < target) begin
      @(posedge clk0_tb);
    end
  endtask

  task automatic expect_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    tests_run = tests_run + 1;
    if (exp_q.size() != 0) begin
      $display("%s: %0d input words never came out", name, exp_q.size());
      errors = errors + 1;
    end
    if (errors != err0) begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d errors", name, errors - err0);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // **************************************************
  // tests
  // **************************************************

  task automatic check_init();
    int err0;
    int cyc;
    err0 = errors;
    @(negedge clk0_tb);
    expect_bit("in_ready", in_ready, 1'b0);
    expect_bit("out_valid", out_valid, 1'b0);
    expect_bit("init_done", init_done, 1'b0);
    while (!locked) begin
      @(negedge clk0_tb);
    end
    cyc = 0;
    while (!init_done && cyc <= INIT_CYCLES + 4) begin
      expect_bit("in_ready", in_ready, 1'b0);
      expect_bit("out_valid", out_valid, 1'b0);
      @(negedge clk0_tb);
      cyc = cyc + 1;
    end
    if (!init_done) begin
      $display("init_done did not rise within %0d cycles of reset release", INIT_CYCLES + 4);
      errors = errors + 1;
    end
    finish_test("reset and init", err0);
  endtask

  task automatic run_stream(input string name, input int n, input int gap_pct,
                            input int rdy_pct);
    int err0;
    int target;
    err0      = errors;
    target    = out_count + n;
    ready_pct = rdy_pct;
    send_words(n, gap_pct);
    wait_output(target);
    finish_test(name, err0);
  endtask

  // one word short of a burst must stay inside.
  task automatic check_burst_hold();
    int err0;
    int first;
    int early;
    err0      = errors;
    ready_pct = 100;
    first     = out_count;
    early     = 0;
    send_words(2 * BURST_LEN - 1, 0);
    for (int c = 0; c < 50; c++) begin
      @(negedge clk0_tb);
      if (out_valid) begin
        early = early + 1;
      end
    end
    if (early != 0) begin
      $display("output appeared while its burst was still incomplete");
      errors = errors + 1;
    end
    send_words(1, 0);
    wait_output(first + 2 * BURST_LEN);
    repeat (20) @(posedge clk0_tb);
    if (out_count != first + 2 * BURST_LEN) begin
      $display("mismatch output word count: expected 0x%h, actual 0x%h",
               2 * BURST_LEN, out_count - first);
      errors = errors + 1;
    end
    finish_test("burst hold", err0);
  endtask

  initial begin : main
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    rng_in       = SEED;
    rng_out      = ~SEED;
    ready_pct    = 100;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    out_count    = 0;

    check_init();
    run_stream("streaming", 64, 0, 100);
    run_stream("back-pressure", 128, 25, 30);
    check_burst_hold();
    run_stream("address wrap", 600, 10, 70);

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk0_tb);
      cycles = cycles + 1;
    end
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* filelist.f */
logic/mem_pkg.sv
logic/stream_pkg.sv
logic/word_packer.sv
logic/word_fifo.sv
logic/burst_scheduler.sv
logic/burst_memory.sv
logic/word_unpacker.sv
logic/mem_loop_top.sv
tests/tb_clock.sv
tests/tb_assert.sv
tests/tb_top.sv

/* Makefile */
TOP = tb_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'Simulation finished: PASS'

clean:
	rm -rf obj_dir
